// File: rtl/hwpe_ctrl_pkg.sv
`default_nettype none

package hwpe_ctrl_pkg;

  // Capacity of the controller
  localparam int unsigned N_CONTEXT        = 2;
  localparam int unsigned N_IO_REGS        = 2;
  localparam int unsigned N_GENERIC_REGS   = 1;
  localparam int unsigned N_MANDATORY_REGS = 7;
  localparam int unsigned N_RESERVED_REGS  = 1;

  // Register map, word indices within one context
  localparam int unsigned GENERIC_BASE = N_MANDATORY_REGS + N_RESERVED_REGS;
  localparam int unsigned IO_BASE      = 16;
  localparam int unsigned LOG_REGS     = 5;
  localparam int unsigned ADDR_W       = 6;
  localparam int unsigned ID_W         = 4;

  // Storage holds the generic words first, then the contexted words
  localparam int unsigned MEM_WORDS  = N_GENERIC_REGS + N_CONTEXT * N_IO_REGS;
  localparam int unsigned MEM_ADDR_W = 3;

  localparam int signed RESP_ANOTHER_PE_OFFLOADING = -2;
  localparam int signed RESP_ALL_CXT_BUSY          = -1;

  localparam int unsigned REG_TRIGGER     = 0;
  localparam int unsigned REG_ACQUIRE     = 1;
  localparam int unsigned REG_FINISHED    = 2;
  localparam int unsigned REG_STATUS      = 3;
  localparam int unsigned REG_RUNNING_JOB = 4;
  localparam int unsigned REG_LAST_CXT    = 5;
  localparam int unsigned REG_SOURCE      = 6;

  typedef logic [31:0]       word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [0:0]        cxt_t;
  typedef logic [7:0]        job_id_t;
  typedef logic [ID_W-1:0]   src_id_t;

  // Peripheral port, wen is high for a write
  typedef struct packed {
    logic       req;
    logic       wen;
    addr_t      addr;
    logic [3:0] be;
    word_t      wdata;
    src_id_t    id;
  } periph_req_t;

  typedef struct packed {
    logic  r_valid;
    word_t rdata;
  } periph_rsp_t;

  typedef struct packed {
    logic       rden;
    logic       wren;
    addr_t      addr;
    word_t      wdata;
    logic [3:0] be;
    src_id_t    src;
  } regfile_in_t;

  typedef struct packed {
    word_t rdata;
  } regfile_out_t;

  typedef struct packed {
    logic is_read;
    logic is_testset;
    logic is_trigger;
    logic is_mandatory;
    logic is_contexted;
    logic is_critical;
    logic full_context;
    logic true_done;
    cxt_t pointer_context;
    cxt_t running_context;
  } flags_regfile_t;

  typedef struct packed {
    word_t [N_IO_REGS-1:0]      hwpe_params;
    word_t [N_GENERIC_REGS-1:0] generic_params;
  } ctrl_regfile_t;

endpackage

`default_nettype wire

// File: rtl/hwpe_ctrl_regfile_mem.sv
`timescale 1ns/10ps
`default_nettype none

module hwpe_ctrl_regfile_mem
  import hwpe_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  re_i,
  input  logic [MEM_ADDR_W-1:0] raddr_i,
  input  logic [MEM_ADDR_W-1:0] waddr_i,
  input  logic                  we_i,
  input  word_t                 wdata_i,
  input  logic [3:0]            be_i,
  output word_t                 rdata_o,
  output word_t                 mem_o [MEM_WORDS]
);

  word_t mem_q [MEM_WORDS];

  // Byte-enabled write, clear wins over a write in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < MEM_WORDS; w++) mem_q[w] <= '0;
    end else if (clear_i) begin
      for (int w = 0; w < MEM_WORDS; w++) mem_q[w] <= '0;
    end else if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  assign rdata_o = re_i ? mem_q[raddr_i] : '0;
  assign mem_o   = mem_q;

endmodule

`default_nettype wire

// File: rtl/hwpe_ctrl_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module hwpe_ctrl_regfile
  import hwpe_ctrl_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  input  regfile_in_t    regfile_in_i,
  input  flags_regfile_t flags_i,
  output regfile_out_t   regfile_out_o,
  output ctrl_regfile_t  reg_file_o
);

  logic [LOG_REGS-1:0]       reg_idx;
  cxt_t                      acc_cxt;
  logic [1:0]                startup_q;
  logic                      startup_clear;
  logic [MEM_ADDR_W-1:0]     mem_addr;
  logic                      mem_valid;
  word_t                     mem_rdata;
  word_t                     mem_words [MEM_WORDS];
  word_t                     mandatory_rdata;
  word_t                     rdata_q;
  job_id_t                   offload_job_id_q;
  job_id_t                   running_job_id_q;
  logic                      running_incr_q;
  logic [N_CONTEXT-1:0][7:0] status_q;
  logic [N_CONTEXT-1:0][7:0] source_q;
  cxt_t                      last_cxt_q;
  logic [1:0]                finished_cnt_q;
  logic [7:0]                src_onehot;
  logic                      grant;

  assign reg_idx = regfile_in_i.addr[LOG_REGS-1:0];
  assign acc_cxt = regfile_in_i.addr[ADDR_W-1];

  // Storage is cleared during the first two cycles out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      startup_q <= '0;
    end else begin
      startup_q <= {startup_q[0], 1'b1};
    end
  end
  assign startup_clear = ~startup_q[1];

  // Contexted words sit past the generic ones, N_IO_REGS per context
  always_comb begin
    if (flags_i.is_contexted) begin
      mem_addr  = MEM_ADDR_W'(N_GENERIC_REGS + acc_cxt * N_IO_REGS + reg_idx - IO_BASE);
      mem_valid = reg_idx < LOG_REGS'(IO_BASE + N_IO_REGS);
    end else begin
      mem_addr  = MEM_ADDR_W'(reg_idx - GENERIC_BASE);
      mem_valid = (reg_idx >= LOG_REGS'(GENERIC_BASE)) &&
                  (reg_idx < LOG_REGS'(GENERIC_BASE + N_GENERIC_REGS));
    end
  end

  hwpe_ctrl_regfile_mem i_regfile_mem (
    .clk_i   ( clk_i                                              ),
    .rst_ni  ( rst_ni                                             ),
    .clear_i ( clear_i | startup_clear                            ),
    .re_i    ( flags_i.is_read & mem_valid                        ),
    .raddr_i ( mem_addr                                           ),
    .waddr_i ( mem_addr                                           ),
    .we_i    ( regfile_in_i.wren & ~flags_i.is_mandatory & mem_valid ),
    .wdata_i ( regfile_in_i.wdata                                 ),
    .be_i    ( regfile_in_i.be                                    ),
    .rdata_o ( mem_rdata                                          ),
    .mem_o   ( mem_words                                          )
  );

  // The running context's parameters feed the engine directly
  always_comb begin
    for (int p = 0; p < N_IO_REGS; p++) begin
      reg_file_o.hwpe_params[p] =
        mem_words[N_GENERIC_REGS + int'(flags_i.running_context) * N_IO_REGS + p];
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      reg_file_o.generic_params[g] = mem_words[g];
    end
  end

  always_comb begin
    case (reg_idx)
      LOG_REGS'(REG_FINISHED):    mandatory_rdata = word_t'(finished_cnt_q);
      LOG_REGS'(REG_STATUS):      mandatory_rdata = word_t'(status_q);
      LOG_REGS'(REG_RUNNING_JOB): mandatory_rdata = word_t'(running_job_id_q);
      LOG_REGS'(REG_LAST_CXT):    mandatory_rdata = word_t'(last_cxt_q);
      LOG_REGS'(REG_SOURCE):      mandatory_rdata = word_t'(source_q);
      default:                    mandatory_rdata = '0;
    endcase
  end

  assign grant = flags_i.is_testset & ~flags_i.is_critical & ~flags_i.full_context;

  // Read data and acquire responses leave through one register
  always_ff @(posedge clk_i) begin
    if (flags_i.is_testset) begin
      if (flags_i.is_critical) begin
        rdata_q <= word_t'(RESP_ANOTHER_PE_OFFLOADING);
      end else if (flags_i.full_context) begin
        rdata_q <= word_t'(RESP_ALL_CXT_BUSY);
      end else begin
        rdata_q <= word_t'(offload_job_id_q);
      end
    end else if (flags_i.is_read) begin
      rdata_q <= flags_i.is_mandatory ? mandatory_rdata : mem_rdata;
    end
  end
  assign regfile_out_o.rdata = rdata_q;

  // Ids outside 0 to 7 give an empty one-hot
  assign src_onehot = 8'd1 << regfile_in_i.src;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_job_id_q <= '0;
      running_job_id_q <= '0;
      running_incr_q   <= 1'b0;
      status_q         <= '0;
      source_q         <= '0;
      last_cxt_q       <= '0;
      finished_cnt_q   <= '0;
    end else if (clear_i) begin
      offload_job_id_q <= '0;
      running_job_id_q <= '0;
      running_incr_q   <= 1'b0;
      status_q         <= '0;
      source_q         <= '0;
      last_cxt_q       <= '0;
      finished_cnt_q   <= '0;
    end else begin
      if (grant) offload_job_id_q <= offload_job_id_q + 8'd1;
      // Running id follows done through one extra register stage
      running_incr_q <= flags_i.true_done;
      if (running_incr_q) running_job_id_q <= running_job_id_q + 8'd1;
      if (regfile_in_i.rden | regfile_in_i.wren) last_cxt_q <= acc_cxt;
      for (int c = 0; c < N_CONTEXT; c++) begin
        if (flags_i.is_trigger && flags_i.pointer_context == cxt_t'(c)) begin
          status_q[c] <= 8'd1;
          source_q[c] <= src_onehot + 8'd1;
        end else if (flags_i.true_done && flags_i.running_context == cxt_t'(c)) begin
          status_q[c] <= 8'd0;
        end
      end
      if (flags_i.is_mandatory && reg_idx == LOG_REGS'(REG_FINISHED)) begin
        finished_cnt_q <= '0;
      end else if (flags_i.true_done && finished_cnt_q < 2'd2) begin
        finished_cnt_q <= finished_cnt_q + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/hwpe_ctrl_slave.sv
`timescale 1ns/10ps
`default_nettype none

module hwpe_ctrl_slave
  import hwpe_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  periph_req_t   periph_req_i,
  output periph_rsp_t   periph_rsp_o,
  input  logic          done_i,
  output logic          engine_start_o,
  output ctrl_regfile_t reg_file_o,
  output logic          busy_o
);

  logic [LOG_REGS-1:0]            reg_idx;
  logic                           acquired_q;
  logic [$clog2(N_CONTEXT+1)-1:0] job_cnt_q;
  cxt_t                           pointer_cxt_q;
  cxt_t                           running_cxt_q;
  logic                           engine_active_q;
  logic                           r_valid_q;
  logic                           grant;
  regfile_in_t                    regfile_in;
  regfile_out_t                   regfile_out;
  flags_regfile_t                 flags;

  assign reg_idx = periph_req_i.addr[LOG_REGS-1:0];

  always_comb begin
    regfile_in.rden  = periph_req_i.req & ~periph_req_i.wen;
    regfile_in.wren  = periph_req_i.req & periph_req_i.wen;
    regfile_in.addr  = periph_req_i.addr;
    regfile_in.wdata = periph_req_i.wdata;
    regfile_in.be    = periph_req_i.be;
    regfile_in.src   = periph_req_i.id;
  end

  // A trigger only counts when it follows a granted acquire
  always_comb begin
    flags.is_mandatory    = periph_req_i.req & (reg_idx < LOG_REGS'(GENERIC_BASE));
    flags.is_testset      = regfile_in.rden & (reg_idx == LOG_REGS'(REG_ACQUIRE));
    flags.is_read         = regfile_in.rden & (reg_idx != LOG_REGS'(REG_ACQUIRE));
    flags.is_trigger      = regfile_in.wren & (reg_idx == LOG_REGS'(REG_TRIGGER)) & acquired_q;
    flags.is_contexted    = reg_idx >= LOG_REGS'(IO_BASE);
    flags.is_critical     = acquired_q;
    flags.full_context    = int'(job_cnt_q) == N_CONTEXT;
    flags.true_done       = done_i;
    flags.pointer_context = pointer_cxt_q;
    flags.running_context = running_cxt_q;
  end

  assign grant = flags.is_testset & ~acquired_q & ~flags.full_context;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acquired_q      <= 1'b0;
      job_cnt_q       <= '0;
      pointer_cxt_q   <= '0;
      running_cxt_q   <= '0;
      engine_active_q <= 1'b0;
      r_valid_q       <= 1'b0;
    end else if (clear_i) begin
      acquired_q      <= 1'b0;
      job_cnt_q       <= '0;
      pointer_cxt_q   <= '0;
      running_cxt_q   <= '0;
      engine_active_q <= 1'b0;
      r_valid_q       <= 1'b0;
    end else begin
      if (grant) begin
        acquired_q <= 1'b1;
      end else if (flags.is_trigger) begin
        acquired_q <= 1'b0;
      end
      if (flags.is_trigger) pointer_cxt_q <= pointer_cxt_q + 1'b1;
      if (done_i) running_cxt_q <= running_cxt_q + 1'b1;
      // Queue holds triggered jobs, including the one that runs
      case ({flags.is_trigger, done_i})
        2'b10:   job_cnt_q <= job_cnt_q + 1'b1;
        2'b01:   job_cnt_q <= job_cnt_q - 1'b1;
        default: job_cnt_q <= job_cnt_q;
      endcase
      if (engine_start_o) begin
        engine_active_q <= 1'b1;
      end else if (done_i) begin
        engine_active_q <= 1'b0;
      end
      r_valid_q <= regfile_in.rden;
    end
  end

  // The oldest queued job starts as soon as the engine is free
  assign engine_start_o = ~clear_i & ~engine_active_q & (job_cnt_q != '0);
  assign busy_o         = ~clear_i & (job_cnt_q != '0);

  assign periph_rsp_o.r_valid = r_valid_q & ~clear_i;
  assign periph_rsp_o.rdata   = regfile_out.rdata;

  hwpe_ctrl_regfile i_regfile (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .regfile_in_i  ( regfile_in  ),
    .flags_i       ( flags       ),
    .regfile_out_o ( regfile_out ),
    .reg_file_o    ( reg_file_o  )
  );

endmodule

`default_nettype wire

// File: rtl/hwpe_job_engine.sv
`timescale 1ns/10ps
`default_nettype none

module hwpe_job_engine
  import hwpe_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          start_i,
  input  ctrl_regfile_t reg_file_i,
  output logic          done_o
);

  word_t run_len;
  word_t cnt_q;
  logic  active_q;

  // A zero run length still takes one cycle
  assign run_len = (reg_file_i.hwpe_params[0] == '0) ? word_t'(1) : reg_file_i.hwpe_params[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (start_i) begin
      cnt_q    <= run_len;
      active_q <= 1'b1;
    end else if (active_q) begin
      cnt_q <= cnt_q - word_t'(1);
      if (cnt_q == word_t'(1)) active_q <= 1'b0;
    end
  end

  // Done falls in the last counted cycle, P cycles after start
  assign done_o = active_q & (cnt_q == word_t'(1)) & ~clear_i;

endmodule

`default_nettype wire

// File: rtl/hwpe_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module hwpe_ctrl_top
  import hwpe_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  periph_req_t periph_req_i,
  output periph_rsp_t periph_rsp_o,
  output logic        evt_o,
  output logic        busy_o
);

  logic          engine_start;
  logic          engine_done;
  ctrl_regfile_t reg_file;

  hwpe_ctrl_slave i_slave (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .periph_req_i   ( periph_req_i ),
    .periph_rsp_o   ( periph_rsp_o ),
    .done_i         ( engine_done  ),
    .engine_start_o ( engine_start ),
    .reg_file_o     ( reg_file     ),
    .busy_o         ( busy_o       )
  );

  hwpe_job_engine i_engine (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .clear_i    ( clear_i      ),
    .start_i    ( engine_start ),
    .reg_file_i ( reg_file     ),
    .done_o     ( engine_done  )
  );

  // One event line, raised for every finished job
  assign evt_o = engine_done;

endmodule

`default_nettype wire

// File: tb/tb_hwpe_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hwpe_ctrl
  import hwpe_ctrl_pkg::*;
();

  localparam int unsigned WATCHDOG_CYCLES = 2000;
  localparam int unsigned EVT_TIMEOUT     = 200;

  // Generic word, then context 0 words, then context 1 words
  localparam addr_t PARAM_ADDR [MEM_WORDS] = '{6'd8, 6'd16, 6'd17, 6'd48, 6'd49};

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  periph_req_t bus_req;
  periph_rsp_t bus_rsp;
  logic        evt_o;
  logic        busy_o;

  int unsigned errors = 0;
  int unsigned cycle_cnt = 0;
  int unsigned evt_stamps [$];
  word_t       exp_mem [MEM_WORDS];
  job_id_t     exp_job_id;
  int unsigned len_cxt0;
  int unsigned len_cxt1;
  int unsigned trig_stamp0;
  src_id_t     trig_id0;
  src_id_t     trig_id1;

  hwpe_ctrl_top dut (
    .clk_i        ( clk_i   ),
    .rst_ni       ( rst_ni  ),
    .clear_i      ( clear_i ),
    .periph_req_i ( bus_req ),
    .periph_rsp_o ( bus_rsp ),
    .evt_o        ( evt_o   ),
    .busy_o       ( busy_o  )
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // Each event is stamped with the cycle it was seen in
  always @(negedge clk_i) begin
    if (evt_o) evt_stamps.push_back(cycle_cnt);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog timeout after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  task automatic check_word(input string name, input word_t exp_w, input word_t act_w);
    if (act_w !== exp_w) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp_w, act_w);
    end
  endtask

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [3:0] be);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Source byte is the one-hot of the id plus one
  function automatic logic [7:0] source_code(src_id_t id);
    return (8'd1 << id) + 8'd1;
  endfunction

  task automatic write_reg(input addr_t addr, input word_t data, input logic [3:0] be,
                           input src_id_t id);
    @(posedge clk_i);
    bus_req.req   <= 1'b1;
    bus_req.wen   <= 1'b1;
    bus_req.addr  <= addr;
    bus_req.be    <= be;
    bus_req.wdata <= data;
    bus_req.id    <= id;
    @(posedge clk_i);
    bus_req.req <= 1'b0;
    // A write gets no response
    @(negedge clk_i);
    if (bus_rsp.r_valid) begin
      errors++;
      $display("A read response was raised for the write to address %0d", addr);
    end
  endtask

  task automatic read_reg(input addr_t addr, output word_t data);
    @(posedge clk_i);
    bus_req.req   <= 1'b1;
    bus_req.wen   <= 1'b0;
    bus_req.addr  <= addr;
    bus_req.be    <= 4'hf;
    bus_req.wdata <= '0;
    bus_req.id    <= src_id_t'($urandom % 16);
    @(posedge clk_i);
    bus_req.req <= 1'b0;
    // The response is due exactly one cycle after the request
    @(negedge clk_i);
    if (!bus_rsp.r_valid) begin
      errors++;
      $display("No read response one cycle after the read of address %0d", addr);
    end
    data = bus_rsp.rdata;
  endtask

  // The stamp is taken in the cycle the trigger sits on the bus
  task automatic trigger_job(input src_id_t id, output int unsigned stamp);
    @(posedge clk_i);
    bus_req.req   <= 1'b1;
    bus_req.wen   <= 1'b1;
    bus_req.addr  <= addr_t'(REG_TRIGGER);
    bus_req.be    <= 4'hf;
    bus_req.wdata <= $urandom;
    bus_req.id    <= id;
    @(negedge clk_i);
    stamp = cycle_cnt;
    @(posedge clk_i);
    bus_req.req <= 1'b0;
  endtask

  task automatic wait_evt(input int unsigned count);
    int unsigned waited;
    waited = 0;
    while (evt_stamps.size() < count && waited < EVT_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (evt_stamps.size() < count) begin
      errors++;
      $display("Event number %0d was never raised", count);
    end
  endtask

  task automatic test_regs();
    word_t      data;
    word_t      wdata;
    logic [3:0] be;
    read_reg(addr_t'(REG_FINISHED), data);
    check_word("reset finished", '0, data);
    read_reg(addr_t'(REG_STATUS), data);
    check_word("reset status", '0, data);
    read_reg(addr_t'(REG_RUNNING_JOB), data);
    check_word("reset running job", '0, data);
    for (int i = 0; i < MEM_WORDS; i++) begin
      read_reg(PARAM_ADDR[i], data);
      check_word("reset params", '0, data);
      exp_mem[i] = '0;
    end
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        wdata = $urandom;
        be    = 4'($urandom);
        write_reg(PARAM_ADDR[i], wdata, be, src_id_t'($urandom % 16));
        exp_mem[i] = merge_bytes(exp_mem[i], wdata, be);
      end
      // Reading every word back also shows the contexts stay apart
      for (int i = 0; i < MEM_WORDS; i++) begin
        read_reg(PARAM_ADDR[i], data);
        check_word("param readback", exp_mem[i], data);
      end
    end
  endtask

  task automatic test_acquire();
    word_t data;
    read_reg(addr_t'(REG_ACQUIRE), data);
    check_word("first acquire", word_t'(exp_job_id), data);
    exp_job_id++;
    // A pending acquire makes the next one answer minus two
    read_reg(addr_t'(REG_ACQUIRE), data);
    check_word("second acquire", 32'hffff_fffe, data);
  endtask

  task automatic test_queue_full();
    word_t       data;
    int unsigned stamp;
    len_cxt0 = 50 + $urandom % 20;
    len_cxt1 = 16 + $urandom % 8;
    trig_id0 = src_id_t'($urandom % 8);
    trig_id1 = src_id_t'($urandom % 8);
    write_reg(PARAM_ADDR[1], word_t'(len_cxt0), 4'hf, trig_id0);
    trigger_job(trig_id0, trig_stamp0);
    read_reg(addr_t'(REG_ACQUIRE), data);
    check_word("acquire context 1", word_t'(exp_job_id), data);
    exp_job_id++;
    write_reg(PARAM_ADDR[3], word_t'(len_cxt1), 4'hf, trig_id1);
    trigger_job(trig_id1, stamp);
    read_reg(addr_t'(REG_ACQUIRE), data);
    check_word("acquire when full", 32'hffff_ffff, data);
    check_word("busy when full", word_t'(1), word_t'(busy_o));
    read_reg(addr_t'(REG_STATUS), data);
    check_word("status queued", 32'h0000_0101, data);
    read_reg(addr_t'(REG_SOURCE), data);
    check_word("source ids", {16'h0, source_code(trig_id1), source_code(trig_id0)}, data);
  endtask

  // Start follows one cycle after the trigger or the previous done
  task automatic test_job_order();
    word_t data;
    wait_evt(1);
    check_word("first job latency", word_t'(trig_stamp0 + len_cxt0 + 1),
               word_t'(evt_stamps[0]));
    read_reg(addr_t'(REG_STATUS), data);
    check_word("status after first job", 32'h0000_0100, data);
    wait_evt(2);
    check_word("second job latency", word_t'(evt_stamps[0] + len_cxt1 + 1),
               word_t'(evt_stamps[1]));
    read_reg(addr_t'(REG_STATUS), data);
    check_word("status after jobs", '0, data);
    read_reg(addr_t'(REG_RUNNING_JOB), data);
    check_word("running job id", word_t'(2), data);
    check_word("busy after jobs", '0, word_t'(busy_o));
  endtask

  task automatic test_finished_sat();
    word_t       data;
    int unsigned stamp;
    int unsigned run_len;
    src_id_t     id;
    run_len = 5 + $urandom % 6;
    id      = src_id_t'($urandom % 8);
    read_reg(addr_t'(REG_ACQUIRE), data);
    check_word("third acquire", word_t'(exp_job_id), data);
    exp_job_id++;
    write_reg(PARAM_ADDR[1], word_t'(run_len), 4'hf, id);
    trigger_job(id, stamp);
    wait_evt(3);
    check_word("third job latency", word_t'(stamp + run_len + 1), word_t'(evt_stamps[2]));
    read_reg(addr_t'(REG_FINISHED), data);
    check_word("finished saturated", word_t'(2), data);
    read_reg(addr_t'(REG_FINISHED), data);
    check_word("finished after read", '0, data);
  endtask

  task automatic test_clear();
    word_t data;
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    exp_job_id = '0;
    read_reg(addr_t'(REG_ACQUIRE), data);
    check_word("acquire after clear", word_t'(exp_job_id), data);
    read_reg(addr_t'(REG_RUNNING_JOB), data);
    check_word("running job after clear", '0, data);
    for (int i = 0; i < MEM_WORDS; i++) begin
      read_reg(PARAM_ADDR[i], data);
      check_word("params after clear", '0, data);
    end
  endtask

  initial begin
    void'($urandom(32'h6dc5));
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    bus_req    = '0;
    exp_job_id = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Storage clears itself during the first cycles out of reset
    repeat (2) @(posedge clk_i);
    test_regs();
    test_acquire();
    test_queue_full();
    test_job_order();
    test_finished_sat();
    test_clear();
    repeat (2) @(posedge clk_i);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/hwpe_ctrl_pkg.sv
rtl/hwpe_ctrl_regfile_mem.sv
rtl/hwpe_ctrl_regfile.sv
rtl/hwpe_ctrl_slave.sv
rtl/hwpe_job_engine.sv
rtl/hwpe_ctrl_top.sv
tb/tb_hwpe_ctrl.sv

// File: Makefile
TOP := tb_hwpe_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
